/* dv/accel_tb.sv */
// Testbench for accel_top; data memory is unreset, so output block 0 is skipped by rule
module accel_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import accel_pkg::*;

    localparam int         prog_len       = 6;
    localparam int         in_len         = 4;
    localparam int         out_len        = 3;
    localparam logic [7:0] in_base        = 8'h10;
    localparam logic [7:0] out_base       = 8'h40;
    // Scratch sits just past the input block, where a stray host write would land
    localparam logic [7:0] scratch        = in_base + 8'(in_len);
    localparam int         num_blocks     = 6;
    localparam int         timeout_cycles = 200 + 40 * num_blocks;

    typedef logic [in_len-1:0][data_width-1:0]  in_blk_t;
    typedef logic [out_len-1:0][data_width-1:0] out_blk_t;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_push;
    logic [cfg_width-1:0]  cfg_data;
    logic                  cfg_full_n;
    logic                  instr_wen;
    instr_t                instr_data;
    logic                  instr_full_n;
    logic                  in_wen;
    logic [data_width-1:0] in_data;
    logic                  in_full_n;
    logic                  out_ren;
    logic [data_width-1:0] out_data;
    logic                  out_empty_n;

    logic [31:0]           lfsr_state;
    instr_t                prog [prog_len];
    logic [data_width-1:0] ref_mem [2**addr_width];
    logic [data_width-1:0] exp_q [$];
    logic [data_width-1:0] got_q [$];
    logic [data_width-1:0] exp_word;
    logic [data_width-1:0] got_word;
    int                    cmp_count = 0;
    int                    cycle_count;

    accel_top dut_i (
        .clk(clk), .rst_n(rst_n), .cfg_push(cfg_push), .cfg_data(cfg_data),
        .cfg_full_n(cfg_full_n), .instr_wen(instr_wen), .instr_data(instr_data),
        .instr_full_n(instr_full_n), .in_wen(in_wen), .in_data(in_data),
        .in_full_n(in_full_n), .out_ren(out_ren), .out_data(out_data),
        .out_empty_n(out_empty_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: no complete run within %0d cycles", timeout_cycles);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    // ----------------------------------------------------------------------
    // LFSR, reference model and checks
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step per bit, newest bit lands in the LSB
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[14:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Runs instructions 1 to the end on the model memory after loading one input block
    function automatic out_blk_t compute_block(input in_blk_t blk);
        instr_t   op;
        out_blk_t res;
        for (int i = 0; i < in_len; i++) begin
            ref_mem[in_base + i] = blk[i];
        end
        for (int pc = 1; pc < prog_len; pc++) begin
            op = prog[pc];
            case (op.opcode)
                op_add:  ref_mem[op.dst] = ref_mem[op.src_a] + ref_mem[op.src_b];
                op_sub:  ref_mem[op.dst] = ref_mem[op.src_a] - ref_mem[op.src_b];
                op_xor:  ref_mem[op.dst] = ref_mem[op.src_a] ^ ref_mem[op.src_b];
                default: ;
            endcase
        end
        for (int j = 0; j < out_len; j++) begin
            res[j] = ref_mem[out_base + j];
        end
        return res;
    endfunction

    task automatic check_word(input string name, input logic [data_width-1:0] exp,
                              input logic [data_width-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s expected %b actual %b", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "handshake level mismatch");
        end
    endtask

    // Output words meet their expected values in order
    always @(posedge clk) begin
        if (got_q.size() > 0 && exp_q.size() > 0) begin
            exp_word = exp_q.pop_front();
            got_word = got_q.pop_front();
            check_word($sformatf("block%0d_word%0d", cmp_count / out_len + 1,
                                 cmp_count % out_len), exp_word, got_word);
            cmp_count++;
        end
    end

    // ----------------------------------------------------------------------
    // Host drivers
    // ----------------------------------------------------------------------
    task automatic build_program();
        prog[0] = '{opcode: op_io,  dst: 8'h00,        src_a: 8'h00,        src_b: 8'h00};
        prog[1] = '{opcode: op_add, dst: scratch,      src_a: in_base,      src_b: in_base + 8'd1};
        prog[2] = '{opcode: op_sub, dst: out_base,     src_a: scratch,      src_b: in_base + 8'd2};
        prog[3] = '{opcode: op_xor, dst: out_base + 8'd1, src_a: in_base + 8'd3, src_b: scratch};
        prog[4] = '{opcode: op_sub, dst: out_base + 8'd2, src_a: in_base, src_b: in_base + 8'd3};
        // Reads back two results written earlier in the same pass
        prog[5] = '{opcode: op_add, dst: out_base + 8'd2, src_a: out_base + 8'd2, src_b: out_base};
    endtask

    task automatic push_config();
        logic [cfg_width-1:0] cfg_bytes [num_configs];
        cfg_bytes[cfg_instr_max]  = 8'(prog_len - 1);
        cfg_bytes[cfg_in_max]     = 8'(in_len - 1);
        cfg_bytes[cfg_in_offset]  = in_base;
        cfg_bytes[cfg_out_max]    = 8'(out_len - 1);
        cfg_bytes[cfg_out_offset] = out_base;
        for (int i = 0; i < num_configs; i++) begin
            check_flag("cfg_full_n before push", 1'b1, cfg_full_n);
            cfg_push = 1'b1;
            cfg_data = cfg_bytes[i];
            @(negedge clk);
        end
        cfg_push = 1'b0;
    endtask

    task automatic load_program();
        int accepted;
        accepted = 0;
        while (!instr_full_n) begin
            @(negedge clk);
        end
        while (accepted < prog_len) begin
            check_flag($sformatf("instr_full_n after %0d writes", accepted), 1'b1, instr_full_n);
            instr_wen  = (take_bits(2) != 0);
            instr_data = prog[accepted];
            if (instr_wen) begin
                accepted++;
            end
            @(negedge clk);
        end
        instr_wen = 1'b0;
        check_flag("instr_full_n after last write", 1'b0, instr_full_n);
    endtask

    // One halt: write an input block and read an output block under random stalls
    task automatic run_exchange(input int blk);
        in_blk_t  words;
        out_blk_t exp_blk;
        int       in_acc;
        int       out_acc;
        logic     done;
        in_acc  = 0;
        out_acc = 0;
        done    = 1'b0;
        // Junk offered while closed must never reach memory
        while (!in_full_n) begin
            check_flag("out_empty_n before exchange", 1'b0, out_empty_n);
            in_wen  = 1'b1;
            in_data = take_bits(16);
            @(negedge clk);
        end
        while (!done) begin
            check_flag($sformatf("in_full_n block%0d", blk), in_acc < in_len, in_full_n);
            check_flag($sformatf("out_empty_n block%0d", blk), out_acc < out_len, out_empty_n);
            if (in_acc == in_len && out_acc == out_len) begin
                done = 1'b1;
            end else begin
                if (in_acc < in_len) begin
                    in_wen  = (take_bits(2) != 0);
                    in_data = take_bits(16);
                    if (in_wen) begin
                        words[in_acc] = in_data;
                        in_acc++;
                    end
                end else begin
                    in_wen  = 1'b1;
                    in_data = take_bits(16);
                end
                if (out_acc < out_len) begin
                    out_ren = (take_bits(2) != 0);
                    if (out_ren) begin
                        if (blk > 0) begin
                            got_q.push_back(out_data);
                        end
                        out_acc++;
                    end
                end else begin
                    out_ren = 1'b0;
                end
                @(negedge clk);
            end
        end
        out_ren = 1'b0;
        if (blk + 1 < num_blocks) begin
            exp_blk = compute_block(words);
            for (int j = 0; j < out_len; j++) begin
                exp_q.push_back(exp_blk[j]);
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        cfg_push   = 1'b0;
        cfg_data   = '0;
        instr_wen  = 1'b0;
        instr_data = '0;
        in_wen     = 1'b0;
        in_data    = '0;
        out_ren    = 1'b0;
        lfsr_state = 32'h2f37;
        build_program();
        for (int a = 0; a < 2**addr_width; a++) begin
            ref_mem[a] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("cfg_full_n after reset", 1'b1, cfg_full_n);
        check_flag("instr_full_n after reset", 1'b0, instr_full_n);
        check_flag("in_full_n after reset", 1'b0, in_full_n);
        check_flag("out_empty_n after reset", 1'b0, out_empty_n);
        push_config();
        load_program();
        for (int b = 0; b < num_blocks; b++) begin
            run_exchange(b);
        end
        while (got_q.size() != 0) begin
            @(negedge clk);
        end
        if (cmp_count == (num_blocks - 1) * out_len) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d output words were compared", cmp_count,
                     (num_blocks - 1) * out_len);
            $display("TESTS FAILED");
            $fatal(1, "output words missing");
        end
    end

endmodule

/* flist.f */
hdl/accel_pkg.sv
hdl/params_fifo.sv
hdl/accel_controller.sv
hdl/data_mem.sv
hdl/vector_core.sv
hdl/accel_top.sv
dv/accel_tb.sv

/* hdl/accel_controller.sv */
// Run sequencer; expects exactly five config bytes and a program whose first halt is op_io
module accel_controller (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [accel_pkg::cfg_width-1:0]        params_dout,
    input  logic                                  params_empty_n,
    output logic                                  params_deq,
    input  logic                                  instr_wen,
    output logic                                  instr_full_n,
    output logic                                  instr_we,
    output logic [accel_pkg::instr_addr_width-1:0] instr_wadr,
    input  logic                                  in_wen,
    output logic                                  in_full_n,
    output logic [accel_pkg::addr_width-1:0]       in_wadr,
    input  logic                                  out_ren,
    output logic                                  out_empty_n,
    output logic [accel_pkg::addr_width-1:0]       out_radr,
    input  logic                                  io_req,
    output logic                                  core_en,
    output accel_pkg::accel_cfg_t                 cfg
);
    import accel_pkg::*;

    // ----------------------------------------------------------------------
    // Config bytes and decode
    // ----------------------------------------------------------------------
    logic [cfg_width-1:0]      cfg_r [num_configs];
    logic [cfg_addr_width-1:0] cfg_idx;

    assign cfg.instr_max  = cfg_r[cfg_instr_max][instr_addr_width-1:0];
    assign cfg.in_max     = cfg_r[cfg_in_max];
    assign cfg.in_offset  = cfg_r[cfg_in_offset];
    assign cfg.out_max    = cfg_r[cfg_out_max];
    assign cfg.out_offset = cfg_r[cfg_out_offset];

    // ----------------------------------------------------------------------
    // State and address counters
    // ----------------------------------------------------------------------
    ctrl_state_t                 state;
    // One extra bit so each counter can pass its limit without wrapping
    logic [instr_addr_width:0]   instr_cnt;
    logic [addr_width:0]         in_cnt;
    logic [addr_width:0]         out_cnt;
    logic [addr_width:0]         in_end;
    logic [addr_width:0]         out_end;
    logic                        in_done;
    logic                        out_done;

    assign in_end   = {1'b0, cfg.in_offset} + {1'b0, cfg.in_max};
    assign out_end  = {1'b0, cfg.out_offset} + {1'b0, cfg.out_max};
    assign in_done  = (in_cnt > in_end);
    assign out_done = (out_cnt > out_end);

    assign params_deq   = params_empty_n && (state == st_idle);
    assign instr_full_n = (state == st_initial_fill) && (instr_cnt <= {1'b0, cfg.instr_max});
    assign instr_we     = instr_wen && instr_full_n;
    assign in_full_n    = (state == st_io_exchange) && !in_done;
    assign out_empty_n  = (state == st_io_exchange) && !out_done;

    assign instr_wadr = instr_cnt[instr_addr_width-1:0];
    assign in_wadr    = in_cnt[addr_width-1:0];
    assign out_radr   = out_cnt[addr_width-1:0];

    always_ff @(posedge clk) begin
        if (params_deq) begin
            cfg_r[cfg_idx] <= params_dout;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            cfg_idx   <= '0;
            instr_cnt <= '0;
            in_cnt    <= '0;
            out_cnt   <= '0;
            core_en   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (params_empty_n) begin
                        cfg_idx <= cfg_idx + 1'b1;
                        if (cfg_idx == num_configs - 1) begin
                            state <= st_initial_fill;
                        end
                    end
                end
                st_initial_fill: begin
                    if (instr_we) begin
                        instr_cnt <= instr_cnt + 1'b1;
                    end
                    // Store full, start the core one cycle after the last write
                    if (!instr_full_n) begin
                        state   <= st_inner_loop;
                        core_en <= 1'b1;
                    end
                end
                st_inner_loop: begin
                    if (io_req) begin
                        core_en <= 1'b0;
                        in_cnt  <= {1'b0, cfg.in_offset};
                        out_cnt <= {1'b0, cfg.out_offset};
                        state   <= st_io_exchange;
                    end
                end
                st_io_exchange: begin
                    if (in_wen && in_full_n) begin
                        in_cnt <= in_cnt + 1'b1;
                    end
                    if (out_ren && out_empty_n) begin
                        out_cnt <= out_cnt + 1'b1;
                    end
                    if (in_done && out_done) begin
                        core_en <= 1'b1;
                        state   <= st_inner_loop;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // The core may only run in the compute phase
    a_en_in_loop: assert property (@(posedge clk) disable iff (!rst_n)
        core_en |-> (state == st_inner_loop));

    // io_req comes from a running core
    a_req_while_en: assert property (@(posedge clk) disable iff (!rst_n)
        io_req |-> core_en);

endmodule

/* hdl/accel_pkg.sv */
// Shared definitions; config fields are single bytes, so data memory is limited to 256 words
package accel_pkg;

    // ----------------------------------------------------------------------
    // Widths and sizes
    // ----------------------------------------------------------------------
    localparam int data_width       = 16;
    localparam int addr_width       = 8;
    localparam int instr_addr_width = 6;
    localparam int cfg_width        = 8;
    localparam int num_configs      = 5;
    localparam int cfg_addr_width   = 3;
    localparam int params_depth     = 8;

    // Config byte order as pushed by the host
    localparam int cfg_instr_max  = 0;
    localparam int cfg_in_max     = 1;
    localparam int cfg_in_offset  = 2;
    localparam int cfg_out_max    = 3;
    localparam int cfg_out_offset = 4;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_xor,
        op_io
    } opcode_t;

    // dst = src_a op src_b, all data memory word addresses
    typedef struct packed {
        opcode_t               opcode;
        logic [addr_width-1:0] dst;
        logic [addr_width-1:0] src_a;
        logic [addr_width-1:0] src_b;
    } instr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_initial_fill,
        st_inner_loop,
        st_io_exchange
    } ctrl_state_t;

    typedef struct packed {
        logic [instr_addr_width-1:0] instr_max;
        logic [addr_width-1:0]       in_max;
        logic [addr_width-1:0]       in_offset;
        logic [addr_width-1:0]       out_max;
        logic [addr_width-1:0]       out_offset;
    } accel_cfg_t;

    typedef struct packed {
        logic                  en;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } core_wr_t;

endpackage

/* hdl/accel_top.sv */
// Accelerator top; the first output block after start-up holds unreset memory contents
module accel_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cfg_push,
    input  logic [accel_pkg::cfg_width-1:0]  cfg_data,
    output logic                             cfg_full_n,
    input  logic                             instr_wen,
    input  accel_pkg::instr_t                instr_data,
    output logic                             instr_full_n,
    input  logic                             in_wen,
    input  logic [accel_pkg::data_width-1:0] in_data,
    output logic                             in_full_n,
    input  logic                             out_ren,
    output logic [accel_pkg::data_width-1:0] out_data,
    output logic                             out_empty_n
);
    import accel_pkg::*;

    logic [cfg_width-1:0]        params_dout;
    logic                        params_empty_n;
    logic                        params_deq;
    logic                        instr_we;
    logic [instr_addr_width-1:0] instr_wadr;
    logic [addr_width-1:0]       in_wadr;
    logic [addr_width-1:0]       out_radr;
    logic                        io_req;
    logic                        core_en;
    accel_cfg_t                  cfg;
    logic [addr_width-1:0]       rd_a_addr;
    logic [addr_width-1:0]       rd_b_addr;
    logic [data_width-1:0]       rd_a_data;
    logic [data_width-1:0]       rd_b_data;
    core_wr_t                    core_wr;
    logic                        host_we;

    // Only accepted host words reach memory
    assign host_we = in_wen && in_full_n;

    params_fifo params_fifo_i (
        .clk(clk), .rst_n(rst_n), .push(cfg_push), .din(cfg_data), .full_n(cfg_full_n),
        .deq(params_deq), .dout(params_dout), .empty_n(params_empty_n)
    );

    accel_controller accel_controller_i (
        .clk(clk), .rst_n(rst_n), .params_dout(params_dout), .params_empty_n(params_empty_n),
        .params_deq(params_deq), .instr_wen(instr_wen), .instr_full_n(instr_full_n),
        .instr_we(instr_we), .instr_wadr(instr_wadr), .in_wen(in_wen), .in_full_n(in_full_n),
        .in_wadr(in_wadr), .out_ren(out_ren), .out_empty_n(out_empty_n), .out_radr(out_radr),
        .io_req(io_req), .core_en(core_en), .cfg(cfg)
    );

    vector_core vector_core_i (
        .clk(clk), .rst_n(rst_n), .core_en(core_en), .cfg_instr_max(cfg.instr_max),
        .instr_we(instr_we), .instr_wadr(instr_wadr), .instr_data(instr_data),
        .rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr), .rd_a_data(rd_a_data),
        .rd_b_data(rd_b_data), .wr(core_wr), .io_req(io_req)
    );

    data_mem data_mem_i (
        .clk(clk), .core_rd_a_addr(rd_a_addr), .core_rd_b_addr(rd_b_addr),
        .core_rd_a_data(rd_a_data), .core_rd_b_data(rd_b_data), .core_wr(core_wr),
        .host_we(host_we), .host_wadr(in_wadr), .host_wdata(in_data),
        .host_radr(out_radr), .host_rdata(out_data)
    );

endmodule

/* hdl/data_mem.sv */
// Shared word memory, unreset; reads are combinational and the core and host never write together
module data_mem (
    input  logic                             clk,
    input  logic [accel_pkg::addr_width-1:0] core_rd_a_addr,
    input  logic [accel_pkg::addr_width-1:0] core_rd_b_addr,
    output logic [accel_pkg::data_width-1:0] core_rd_a_data,
    output logic [accel_pkg::data_width-1:0] core_rd_b_data,
    input  accel_pkg::core_wr_t              core_wr,
    input  logic                             host_we,
    input  logic [accel_pkg::addr_width-1:0] host_wadr,
    input  logic [accel_pkg::data_width-1:0] host_wdata,
    input  logic [accel_pkg::addr_width-1:0] host_radr,
    output logic [accel_pkg::data_width-1:0] host_rdata
);
    import accel_pkg::*;

    logic [data_width-1:0] mem [2**addr_width];

    assign core_rd_a_data = mem[core_rd_a_addr];
    assign core_rd_b_data = mem[core_rd_b_addr];
    assign host_rdata     = mem[host_radr];

    always_ff @(posedge clk) begin
        if (core_wr.en) begin
            mem[core_wr.addr] <= core_wr.data;
        end
        if (host_we) begin
            mem[host_wadr] <= host_wdata;
        end
    end

    // Host writes only open while the controller holds the core halted
    a_one_writer: assert property (@(posedge clk) !(core_wr.en && host_we));

endmodule

/* hdl/params_fifo.sv */
// Config byte FIFO; pushing while full_n is low or dequeuing while empty_n is low is an error
module params_fifo (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           push,
    input  logic [accel_pkg::cfg_width-1:0] din,
    output logic                           full_n,
    input  logic                           deq,
    output logic [accel_pkg::cfg_width-1:0] dout,
    output logic                           empty_n
);
    import accel_pkg::*;

    logic [cfg_width-1:0]              mem [params_depth];
    logic [$clog2(params_depth)-1:0]   wr_ptr;
    logic [$clog2(params_depth)-1:0]   rd_ptr;
    logic [$clog2(params_depth):0]     count;
    logic                              do_push;
    logic                              do_pop;

    assign full_n  = (count != params_depth);
    assign empty_n = (count != 0);
    assign dout    = mem[rd_ptr];
    assign do_push = push && full_n;
    assign do_pop  = deq && empty_n;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> full_n);
    a_no_deq_empty: assert property (@(posedge clk) disable iff (!rst_n) deq |-> empty_n);

endmodule

/* hdl/vector_core.sv */
// Memory-to-memory core, one instruction per enabled cycle; no result forwarding is needed
module vector_core (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  core_en,
    input  logic [accel_pkg::instr_addr_width-1:0] cfg_instr_max,
    input  logic                                  instr_we,
    input  logic [accel_pkg::instr_addr_width-1:0] instr_wadr,
    input  accel_pkg::instr_t                     instr_data,
    output logic [accel_pkg::addr_width-1:0]       rd_a_addr,
    output logic [accel_pkg::addr_width-1:0]       rd_b_addr,
    input  logic [accel_pkg::data_width-1:0]       rd_a_data,
    input  logic [accel_pkg::data_width-1:0]       rd_b_data,
    output accel_pkg::core_wr_t                   wr,
    output logic                                  io_req
);
    import accel_pkg::*;

    // ----------------------------------------------------------------------
    // Instruction store and fetch
    // ----------------------------------------------------------------------
    instr_t                      imem [2**instr_addr_width];
    instr_t                      cur;
    logic [instr_addr_width-1:0] pc;
    logic [instr_addr_width-1:0] pc_next;
    // Set by op_io, held until the controller has dropped core_en
    logic                        stall;
    logic                        exec;
    logic [data_width-1:0]       result;

    always_ff @(posedge clk) begin
        if (instr_we) begin
            imem[instr_wadr] <= instr_data;
        end
    end

    assign cur     = imem[pc];
    assign exec    = core_en && !stall;
    assign pc_next = (pc == cfg_instr_max) ? '0 : pc + 1'b1;

    // ----------------------------------------------------------------------
    // Operand read and ALU
    // ----------------------------------------------------------------------
    assign rd_a_addr = cur.src_a;
    assign rd_b_addr = cur.src_b;

    always_comb begin
        case (cur.opcode)
            op_add:  result = rd_a_data + rd_b_data;
            op_sub:  result = rd_a_data - rd_b_data;
            op_xor:  result = rd_a_data ^ rd_b_data;
            default: result = rd_a_data;
        endcase
    end

    // Result lands in data memory on the same edge that moves the pc
    assign wr.en   = exec && (cur.opcode != op_io);
    assign wr.addr = cur.dst;
    assign wr.data = result;

    // ----------------------------------------------------------------------
    // Sequencing
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= '0;
            stall  <= 1'b0;
            io_req <= 1'b0;
        end else begin
            io_req <= exec && (cur.opcode == op_io);
            if (exec) begin
                pc <= pc_next;
            end
            // pc waits on the instruction after op_io until re-enabled
            if (exec && (cur.opcode == op_io)) begin
                stall <= 1'b1;
            end else if (!core_en) begin
                stall <= 1'b0;
            end
        end
    end

    a_pc_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        core_en |-> (pc <= cfg_instr_max));

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it into a log and checks the log for a pass

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module accel_tb \
    -f flist.f -o accel_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/accel_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
